//--- all.f
design/lc3_mem_pkg.sv
design/lc3_isa_pkg.sv
design/lc3_datapath.sv
design/lc3_control.sv
design/mem_arbiter.sv
design/unified_memory.sv
design/lc3_subsystem_top.sv
sim/tb_lc3_subsystem.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_lc3_subsystem
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

# The run passes only if the pass message shows up in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_lc3_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lc3_subsystem;
    import lc3_isa_pkg::*;
    import lc3_mem_pkg::*;

    localparam int N_RAND    = 40;
    localparam int PROG_LEN  = N_RAND + 9;
    localparam int N_RUNS    = 2;
    localparam int N_SCRATCH = 30;
    localparam int HOST_OPS  = 2 * MEM_DEPTH + N_RUNS * (192 + N_SCRATCH + MEM_DEPTH);
    localparam int WATCHDOG_CYCLES = N_RUNS * PROG_LEN * 200 + HOST_OPS * 10 + 100;

    logic       clk;
    logic       arst_n;
    logic       run_req;
    logic       run_ack;
    logic       host_req;
    mem_req_t   host_cmd;
    logic       host_ack;
    mem_word_t  host_rdata;

    integer     seed;
    mem_word_t  model_mem [MEM_DEPTH];
    mem_word_t  model_reg [8];
    logic [2:0] model_cc;

    lc3_subsystem_top lc3_subsystem_top_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .run_req    (run_req),
        .run_ack    (run_ack),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %h got %h",
                               $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH at %0t ns: %s expected %b got %b",
                               $time, name, exp, act));
    endtask

    // One full four-phase exchange on the host port
    task automatic host_access(input logic we, input logic [15:0] addr,
                               input mem_word_t wdata, output mem_word_t rdata);
        @(negedge clk);
        check_bit("host_ack", 1'b0, host_ack);
        host_cmd.we    = we;
        host_cmd.addr  = addr;
        host_cmd.wdata = wdata;
        host_req       = 1'b1;
        @(negedge clk);
        while (!host_ack)
            @(negedge clk);
        rdata    = host_rdata;
        host_req = 1'b0;
        @(negedge clk);
        while (host_ack)
            @(negedge clk);
    endtask

    function automatic logic [2:0] cc_of(input mem_word_t v);
        if ($signed(v) < 0)
            return 3'b100;
        else if (v == 16'd0)
            return 3'b010;
        else
            return 3'b001;
    endfunction

    // LD and ST land in 128..191 and branches never pass the register dump
    function automatic logic [15:0] rand_instr(input logic [31:0] a);
        logic [31:0] r;
        logic [31:0] kind;
        logic [31:0] t;
        logic [15:0] w;
        r    = $random(seed);
        kind = $random(seed);
        kind = kind % 32'd7;
        case (kind)
            0: w = {OP_ADD, r[2:0], r[5:3], r[6], r[6] ? r[11:7] : {2'b00, r[9:7]}};
            1: w = {OP_AND, r[2:0], r[5:3], r[6], r[6] ? r[11:7] : {2'b00, r[9:7]}};
            2: w = {OP_NOT, r[2:0], r[5:3], 6'b111111};
            3, 4:
            begin
                t = 32'd128 + {26'd0, r[21:16]} - a - 32'd1;
                w = {(kind == 3) ? OP_LD : OP_ST, r[2:0], t[8:0]};
            end
            5: w = {OP_LEA, r[2:0], r[14:6]};
            default:
            begin
                t = {16'd0, r[31:16]} % (N_RAND - a);
                w = {OP_BR, r[2:0], t[8:0]};
            end
        endcase
        return w;
    endfunction

    // Reference ISA execution over the model memory
    task automatic run_model();
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] b;
        logic [15:0] ea;
        logic        done;
        int          steps;
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done)
        begin
            w  = model_mem[pc[MEM_AW-1:0]];
            pc = pc + 16'd1;
            ea = pc + {{7{w[8]}}, w[8:0]};
            b  = w[5] ? {{11{w[4]}}, w[4:0]} : model_reg[w[2:0]];
            case (w[15:12])
                OP_ADD: model_reg[w[11:9]] = model_reg[w[8:6]] + b;
                OP_AND: model_reg[w[11:9]] = model_reg[w[8:6]] & b;
                OP_NOT: model_reg[w[11:9]] = ~model_reg[w[8:6]];
                OP_LD:  model_reg[w[11:9]] = model_mem[ea[MEM_AW-1:0]];
                OP_ST:  model_mem[ea[MEM_AW-1:0]] = model_reg[w[11:9]];
                OP_LEA: model_reg[w[11:9]] = ea;
                OP_BR:
                begin
                    if ((w[11:9] & model_cc) != 3'b000)
                        pc = ea;
                end
                OP_TRAP: done = (w[7:0] == HALT_VECTOR);
                default: fail_run("Model fetched an opcode outside the kept subset");
            endcase
            if (w[15:12] == OP_ADD || w[15:12] == OP_AND || w[15:12] == OP_NOT
                || w[15:12] == OP_LD)
                model_cc = cc_of(model_reg[w[11:9]]);
            steps++;
            if (steps > 1000)
                fail_run("Model never reached the halt trap");
        end
    endtask

    task automatic load_program();
        logic [31:0] r;
        logic [31:0] t;
        mem_word_t   w;
        mem_word_t   unused;
        for (int a = 0; a < 192; a++)
        begin
            r = $random(seed);
            if (a < N_RAND)
                w = rand_instr(a);
            else if (a < N_RAND + 8)
            begin
                // Dump R0..R7 into words 192..199
                t = 32'(a - N_RAND);
                w = {OP_ST, t[2:0], 9'(192 - N_RAND - 1)};
            end
            else if (a == N_RAND + 8)
                w = {OP_TRAP, 4'b0000, HALT_VECTOR};
            else if (a < 128)
                w = 16'h0000;
            else
                w = r[15:0];
            model_mem[a] = w;
            host_access(1'b1, 16'(a), w, unused);
        end
    endtask

    task automatic alias_test();
        logic [31:0] r;
        mem_word_t   got;
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            r = $random(seed);
            model_mem[i] = r[31:16];
            host_access(1'b1, {r[15:8], 8'(i)}, r[31:16], got);
        end
        // Read back through other random upper address bits
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            r = $random(seed);
            host_access(1'b0, {r[15:8], 8'(i)}, 16'h0000, got);
            check_word($sformatf("host_rdata[%0d]", i), model_mem[i], got);
        end
    endtask

    task automatic run_handshake();
        int k;
        @(negedge clk);
        check_bit("run_ack", 1'b0, run_ack);
        run_req = 1'b1;
        while (!run_ack)
            @(negedge clk);
        // Ack holds while the request stays up
        repeat (3)
        begin
            @(negedge clk);
            check_bit("run_ack", 1'b1, run_ack);
        end
        run_req = 1'b0;
        k = 0;
        while (run_ack && k < 4)
        begin
            @(negedge clk);
            k++;
        end
        check_bit("run_ack", 1'b0, run_ack);
        @(negedge clk);
        check_bit("run_ack", 1'b0, run_ack);
    endtask

    // Host traffic in 200..255 competes with the CPU for the memory
    task automatic scratch_traffic();
        logic [31:0] r;
        logic [7:0]  idx;
        mem_word_t   got;
        for (int k = 0; k < N_SCRATCH; k++)
        begin
            r   = $random(seed);
            idx = 8'(32'd200 + {16'd0, r[31:16]} % 32'd56);
            if (r[0])
            begin
                model_mem[idx] = r[15:0];
                host_access(1'b1, {8'h00, idx}, r[15:0], got);
            end
            else
            begin
                host_access(1'b0, {8'h00, idx}, 16'h0000, got);
                check_word($sformatf("host_rdata[%0d]", idx), model_mem[idx], got);
            end
        end
    endtask

    task automatic do_run(input int run_no);
        mem_word_t got;
        load_program();
        run_model();
        fork
            run_handshake();
            scratch_traffic();
        join
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            host_access(1'b0, 16'(i), 16'h0000, got);
            check_word($sformatf("run %0d mem[%0d]", run_no, i), model_mem[i], got);
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog expired, the DUT stopped answering a handshake");
    end

    initial
    begin
        seed     = 85;
        arst_n   = 1'b0;
        run_req  = 1'b0;
        host_req = 1'b0;
        host_cmd = '0;
        for (int i = 0; i < 8; i++)
            model_reg[i] = 16'h0000;
        model_cc = 3'b010;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("run_ack", 1'b0, run_ack);
        check_bit("host_ack", 1'b0, host_ack);
        alias_test();
        // Registers and NZP carry over into the second run
        for (int n = 0; n < N_RUNS; n++)
            do_run(n);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/lc3_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_subsystem_top (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        run_req,
    output logic                       run_ack,
    input  wire                        host_req,
    input  wire lc3_mem_pkg::mem_req_t host_cmd,
    output logic                       host_ack,
    output lc3_mem_pkg::mem_word_t     host_rdata
);
    import lc3_isa_pkg::*;
    import lc3_mem_pkg::*;

    ctrl_word_t ctrl;
    dp_status_t status;
    logic       cpu_req;
    mem_req_t   cpu_cmd;
    logic       cpu_ack;
    mem_word_t  cpu_rdata;
    logic       mem_req;
    mem_req_t   mem_cmd;
    logic       mem_ack;
    mem_word_t  mem_rdata;

    lc3_control lc3_control_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .run_req (run_req),
        .run_ack (run_ack),
        .status  (status),
        .ctrl    (ctrl),
        .cpu_req (cpu_req),
        .cpu_cmd (cpu_cmd),
        .cpu_ack (cpu_ack)
    );

    lc3_datapath lc3_datapath_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl),
        .mem_rdata (cpu_rdata),
        .status    (status)
    );

    mem_arbiter mem_arbiter_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_req    (cpu_req),
        .cpu_cmd    (cpu_cmd),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .host_req   (host_req),
        .host_cmd   (host_cmd),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .mem_req    (mem_req),
        .mem_cmd    (mem_cmd),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    unified_memory unified_memory_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- design/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
    input  wire                        clk,
    input  wire                        arst_n,
    input  wire                        mem_req,
    input  wire lc3_mem_pkg::mem_req_t mem_cmd,
    output logic                       mem_ack,
    output lc3_mem_pkg::mem_word_t     mem_rdata
);
    import lc3_mem_pkg::*;

    mem_word_t         mem [MEM_DEPTH];
    logic [MEM_AW-1:0] idx;
    logic              start;

    // Upper address bits alias onto the low words
    assign idx   = mem_cmd.addr[MEM_AW-1:0];
    assign start = mem_req && !mem_ack;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mem_ack <= 1'b0;
        else
            mem_ack <= mem_req;
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            if (mem_cmd.we)
                mem[idx] <= mem_cmd.wdata;
            mem_rdata <= mem[idx];
        end
    end

    a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(mem_req) |-> !mem_ack);

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         cpu_req,
    input  wire lc3_mem_pkg::mem_req_t  cpu_cmd,
    output logic                        cpu_ack,
    output lc3_mem_pkg::mem_word_t      cpu_rdata,
    input  wire                         host_req,
    input  wire lc3_mem_pkg::mem_req_t  host_cmd,
    output logic                        host_ack,
    output lc3_mem_pkg::mem_word_t      host_rdata,
    output logic                        mem_req,
    output lc3_mem_pkg::mem_req_t       mem_cmd,
    input  wire                         mem_ack,
    input  wire lc3_mem_pkg::mem_word_t mem_rdata
);

    typedef enum logic [1:0] {
        GNT_NONE = 2'b00,
        GNT_CPU  = 2'b01,
        GNT_HOST = 2'b10
    } grant_t;

    grant_t grant;
    logic   last_host;
    logic   pick_host;
    logic   granted_req;

    // On a tie the client not served last wins
    assign pick_host   = host_req && (!cpu_req || !last_host);
    assign granted_req = (grant == GNT_HOST) ? host_req : cpu_req;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            grant     <= GNT_NONE;
            last_host <= 1'b0;
        end
        else if (grant == GNT_NONE)
        begin
            if (cpu_req || host_req)
            begin
                grant     <= pick_host ? GNT_HOST : GNT_CPU;
                last_host <= pick_host;
            end
        end
        else if (!granted_req && !mem_ack)
        begin
            // Both halves of the handshake are back to zero
            grant <= GNT_NONE;
        end
    end

    assign mem_req    = (grant != GNT_NONE) && granted_req;
    assign mem_cmd    = (grant == GNT_HOST) ? host_cmd : cpu_cmd;
    assign cpu_ack    = (grant == GNT_CPU) && mem_ack;
    assign host_ack   = (grant == GNT_HOST) && mem_ack;
    assign cpu_rdata  = (grant == GNT_CPU) ? mem_rdata : '0;
    assign host_rdata = (grant == GNT_HOST) ? mem_rdata : '0;

    a_grant_held: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_req || mem_ack) |=> $stable(grant));

endmodule

`default_nettype wire

//--- design/lc3_control.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_control (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          run_req,
    output logic                         run_ack,
    input  wire lc3_isa_pkg::dp_status_t status,
    output lc3_isa_pkg::ctrl_word_t      ctrl,
    output logic                         cpu_req,
    output lc3_mem_pkg::mem_req_t        cpu_cmd,
    input  wire                          cpu_ack
);
    import lc3_isa_pkg::*;

    typedef enum logic [3:0] {
        IDLE, FETCH_MAR, FETCH_MEM, FETCH_IR, DECODE,
        EX_OPER, EX_LEA, EX_BR, EX_LD, EX_ST, ST_DATA, EX_TRAP,
        MEM_WAIT, MEM_RELEASE, HALTED
    } state_t;

    state_t  state;
    state_t  next;
    opcode_t opcode;
    logic    is_st;

    assign opcode = status.ir.op.opcode;
    assign is_st  = (opcode == OP_ST);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state <= IDLE;
        else
            state <= next;
    end

    always_comb
    begin
        next = state;
        ctrl = '0;
        case (state)
            IDLE:
            begin
                if (run_req)
                begin
                    ctrl.gate    = GATE_PC;
                    ctrl.ld_pc   = 1'b1;
                    ctrl.pc_init = 1'b1;
                    next         = FETCH_MAR;
                end
            end
            FETCH_MAR:
            begin
                ctrl.gate   = GATE_PC;
                ctrl.ld_mar = 1'b1;
                ctrl.ld_pc  = 1'b1;
                next        = FETCH_MEM;
            end
            FETCH_MEM:
            begin
                if (cpu_ack)
                begin
                    ctrl.gate   = GATE_MDR;
                    ctrl.ld_mdr = 1'b1;
                    ctrl.mio_en = 1'b1;
                    next        = FETCH_IR;
                end
            end
            FETCH_IR:
            begin
                // IR keeps reloading the same MDR word until ack drops
                ctrl.gate  = GATE_MDR;
                ctrl.ld_ir = 1'b1;
                if (!cpu_ack)
                    next = DECODE;
            end
            DECODE:
            begin
                case (opcode)
                    OP_ADD, OP_AND, OP_NOT: next = EX_OPER;
                    OP_LEA:  next = EX_LEA;
                    OP_BR:   next = EX_BR;
                    OP_LD:   next = EX_LD;
                    OP_ST:   next = EX_ST;
                    OP_TRAP: next = EX_TRAP;
                    default: next = FETCH_MAR;
                endcase
            end
            EX_OPER:
            begin
                ctrl.gate    = GATE_ALU;
                ctrl.sr1_sel = 1'b1;
                ctrl.dr_sel  = 1'b1;
                ctrl.ld_reg  = 1'b1;
                ctrl.ld_cc   = 1'b1;
                ctrl.alu_op  = (opcode == OP_AND) ? ALU_AND :
                               (opcode == OP_NOT) ? ALU_NOT : ALU_ADD;
                next         = FETCH_MAR;
            end
            EX_LEA:
            begin
                // LEA leaves NZP alone
                ctrl.gate      = GATE_CALC;
                ctrl.addr1_sel = 1'b1;
                ctrl.addr2_sel = ADDR2_OFF9;
                ctrl.dr_sel    = 1'b1;
                ctrl.ld_reg    = 1'b1;
                next           = FETCH_MAR;
            end
            EX_BR:
            begin
                ctrl.gate      = GATE_CALC;
                ctrl.addr1_sel = 1'b1;
                ctrl.addr2_sel = ADDR2_OFF9;
                ctrl.pc_sel    = PC_CALC;
                ctrl.ld_pc     = status.ben;
                next           = FETCH_MAR;
            end
            EX_LD, EX_ST:
            begin
                ctrl.gate      = GATE_CALC;
                ctrl.addr1_sel = 1'b1;
                ctrl.addr2_sel = ADDR2_OFF9;
                ctrl.ld_mar    = 1'b1;
                next           = (state == EX_ST) ? ST_DATA : MEM_WAIT;
            end
            ST_DATA:
            begin
                ctrl.gate   = GATE_ALU;
                ctrl.alu_op = ALU_PASS;
                ctrl.ld_mdr = 1'b1;
                next        = MEM_WAIT;
            end
            EX_TRAP:
            begin
                // Halt does not touch R7
                next = (status.ir.off.pcoffset9[7:0] == HALT_VECTOR) ? HALTED : FETCH_MAR;
            end
            MEM_WAIT:
            begin
                if (cpu_ack)
                begin
                    ctrl.gate   = GATE_MDR;
                    ctrl.ld_mdr = !is_st;
                    ctrl.mio_en = 1'b1;
                    next        = MEM_RELEASE;
                end
            end
            MEM_RELEASE:
            begin
                if (!is_st)
                begin
                    ctrl.gate   = GATE_MDR;
                    ctrl.dr_sel = 1'b1;
                    ctrl.ld_reg = 1'b1;
                    ctrl.ld_cc  = 1'b1;
                end
                if (!cpu_ack)
                    next = FETCH_MAR;
            end
            HALTED:
            begin
                if (!run_req)
                    next = IDLE;
            end
            default: next = IDLE;
        endcase
    end

    assign run_ack       = (state == HALTED);
    assign cpu_req       = (state == FETCH_MEM) || (state == MEM_WAIT);
    assign cpu_cmd.we    = (state == MEM_WAIT) && is_st;
    assign cpu_cmd.addr  = status.mar;
    assign cpu_cmd.wdata = status.mdr;

    a_cmd_held: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_req && !cpu_ack |=> cpu_req && $stable(cpu_cmd));

    a_req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(cpu_req) |-> !cpu_ack);

endmodule

`default_nettype wire

//--- design/lc3_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module lc3_datapath (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire lc3_isa_pkg::ctrl_word_t ctrl,
    input  wire lc3_mem_pkg::mem_word_t  mem_rdata,
    output lc3_isa_pkg::dp_status_t      status
);
    import lc3_isa_pkg::*;
    import lc3_mem_pkg::*;

    lc3_instr_u  ir;
    mem_word_t   pc;
    mem_word_t   mar;
    mem_word_t   mdr;
    mem_word_t   regs [8];
    logic [2:0]  nzp;

    logic [15:0] ir_bits;
    logic [2:0]  dr_idx;
    logic [2:0]  sr1_idx;
    logic [7:0]  reg_we;
    mem_word_t   sr1_val;
    mem_word_t   alu_b;
    mem_word_t   alu_out;
    mem_word_t   addr1;
    mem_word_t   addr2;
    mem_word_t   calc;
    mem_word_t   bus;
    mem_word_t   pc_next;
    mem_word_t   mdr_in;
    logic        any_load;

    assign ir_bits = ir;
    assign dr_idx  = ctrl.dr_sel ? ir.op.dr : 3'b111;
    assign sr1_idx = ctrl.sr1_sel ? ir.op.sr1 : ir.op.dr;
    assign sr1_val = regs[sr1_idx];
    assign alu_b   = ir.op.imm_flag ? {{11{ir.op.imm5[4]}}, ir.op.imm5} : regs[ir.op.imm5[2:0]];

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD: alu_out = sr1_val + alu_b;
            ALU_AND: alu_out = sr1_val & alu_b;
            ALU_NOT: alu_out = ~sr1_val;
            default: alu_out = sr1_val;
        endcase
    end

    // Address adder, PC here is already past the current instruction
    assign addr1 = ctrl.addr1_sel ? pc : sr1_val;

    always_comb
    begin
        case (ctrl.addr2_sel)
            ADDR2_OFF11: addr2 = {{5{ir_bits[10]}}, ir_bits[10:0]};
            ADDR2_OFF9:  addr2 = {{7{ir_bits[8]}}, ir_bits[8:0]};
            ADDR2_OFF6:  addr2 = {{10{ir_bits[5]}}, ir_bits[5:0]};
            default:     addr2 = '0;
        endcase
    end

    assign calc = addr1 + addr2;

    always_comb
    begin
        case (ctrl.gate)
            GATE_CALC: bus = calc;
            GATE_ALU:  bus = alu_out;
            GATE_MDR:  bus = mdr;
            GATE_PC:   bus = pc;
            default:   bus = '0;
        endcase
    end

    always_comb
    begin
        case (ctrl.pc_sel)
            PC_CALC: pc_next = calc;
            PC_BUS:  pc_next = bus;
            default: pc_next = pc + 16'd1;
        endcase
    end

    assign mdr_in = ctrl.mio_en ? mem_rdata : bus;
    assign reg_we = ctrl.ld_reg ? (8'b1 << dr_idx) : 8'b0;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ir  <= '0;
            pc  <= RESET_PC;
            nzp <= 3'b010;
        end
        else
        begin
            if (ctrl.ld_ir)
                ir <= bus;
            if (ctrl.ld_pc)
                pc <= ctrl.pc_init ? RESET_PC : pc_next;
            if (ctrl.ld_cc)
                nzp <= {bus[15], bus == 16'd0, !bus[15] && bus != 16'd0};
        end
    end

    // Register contents survive between runs
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < 8; i++)
                if (reg_we[i])
                    regs[i] <= bus;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ctrl.ld_mar)
            mar <= bus;
        if (ctrl.ld_mdr)
            mdr <= mdr_in;
    end

    assign status.ir  = ir;
    assign status.ben = |(ir.off.dr_nzp & nzp);
    assign status.mar = mar;
    assign status.mdr = mdr;

    assign any_load = |{ctrl.ld_ir, ctrl.ld_pc, ctrl.ld_mar, ctrl.ld_mdr, ctrl.ld_reg, ctrl.ld_cc};

    a_gate_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        any_load |-> $onehot(ctrl.gate));

endmodule

`default_nettype wire

//--- design/lc3_isa_pkg.sv
`default_nettype none

package lc3_isa_pkg;

    localparam logic [15:0] RESET_PC    = 16'h0000;
    localparam logic [7:0]  HALT_VECTOR = 8'h25;

    typedef enum logic [3:0] {
        OP_BR   = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_LD   = 4'b0010,
        OP_ST   = 4'b0011,
        OP_AND  = 4'b0101,
        OP_NOT  = 4'b1001,
        OP_LEA  = 4'b1110,
        OP_TRAP = 4'b1111
    } opcode_t;

    // Register form keeps SR2 in the low three bits of imm5
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm_flag;
        logic [4:0] imm5;
    } instr_op_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] dr_nzp;
        logic [8:0] pcoffset9;
    } instr_off_t;

    typedef union packed {
        instr_op_t  op;
        instr_off_t off;
    } lc3_instr_u;

    typedef enum logic [3:0] {
        GATE_NONE = 4'b0000,
        GATE_CALC = 4'b0001,
        GATE_ALU  = 4'b0010,
        GATE_MDR  = 4'b0100,
        GATE_PC   = 4'b1000
    } bus_gate_t;

    typedef enum logic [1:0] {
        PC_INCR = 2'b00,
        PC_CALC = 2'b10,
        PC_BUS  = 2'b11
    } pc_sel_t;

    typedef enum logic [1:0] {
        ADDR2_OFF11 = 2'b00,
        ADDR2_OFF9  = 2'b01,
        ADDR2_OFF6  = 2'b10,
        ADDR2_ZERO  = 2'b11
    } addr2_sel_t;

    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_AND  = 2'b01,
        ALU_NOT  = 2'b10,
        ALU_PASS = 2'b11
    } alu_op_t;

    // dr_sel 0 picks R7, sr1_sel 0 picks IR[11:9], addr1_sel 1 picks PC
    typedef struct packed {
        logic       ld_ir;
        logic       ld_pc;
        logic       ld_mar;
        logic       ld_mdr;
        logic       ld_reg;
        logic       ld_cc;
        logic       pc_init;
        bus_gate_t  gate;
        pc_sel_t    pc_sel;
        logic       dr_sel;
        logic       sr1_sel;
        logic       addr1_sel;
        addr2_sel_t addr2_sel;
        alu_op_t    alu_op;
        logic       mio_en;
    } ctrl_word_t;

    typedef struct packed {
        lc3_instr_u  ir;
        logic        ben;
        logic [15:0] mar;
        logic [15:0] mdr;
    } dp_status_t;

endpackage

`default_nettype wire

//--- design/lc3_mem_pkg.sv
`default_nettype none

package lc3_mem_pkg;

    localparam int WORD_W    = 16;
    localparam int ADDR_W    = 16;
    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    typedef logic [WORD_W-1:0] mem_word_t;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        mem_word_t         wdata;
    } mem_req_t;

endpackage

`default_nettype wire
